// ==== Bender.yml ====
package:
  name: operand_datapath

sources:
  - source/mem_map_pkg.sv
  - source/isa_pkg.sv
  - source/delay_line.sv
  - source/issue_stage.sv
  - source/operand_lane.sv
  - source/alu.sv
  - source/datapath_top.sv
  - target: simulation
    files:
      - dv/datapath_checker.sv
      - dv/tb_datapath.sv

// ==== build.f ====
source/mem_map_pkg.sv
source/isa_pkg.sv
source/delay_line.sv
source/issue_stage.sv
source/operand_lane.sv
source/alu.sv
source/datapath_top.sv
dv/datapath_checker.sv
dv/tb_datapath.sv

// ==== dv/datapath_checker.sv ====
`timescale 1ns/1ps

module datapath_checker (
    input  logic                                                            clock,
    input  logic                                                            rst,
    input  isa_pkg::instr_t                                                 instr_in,
    input  mem_map_pkg::io_in_t [mem_map_pkg::lane_count-1:0]               io_in,
    input  logic                                                            io_ready,
    input  logic [mem_map_pkg::lane_count-1:0][mem_map_pkg::io_port_count-1:0] io_rden,
    input  isa_pkg::wb_t                                                    wb_out,
    output int                                                              check_count,
    output int                                                              error_count,
    output int                                                              annul_count
);

    logic [mem_map_pkg::word_w-1:0] mem_model [mem_map_pkg::lane_count][mem_map_pkg::mem_depth];
    isa_pkg::wb_t                   expect_q [$];
    isa_pkg::instr_t                issued;    // Instruction held in the issue register

    initial begin
        for (int l = 0; l < mem_map_pkg::lane_count; l++) begin
            for (int i = 0; i < mem_map_pkg::mem_depth; i++) begin
                mem_model[l][i] = '0;
            end
        end
        check_count = 0;
        error_count = 0;
        annul_count = 0;
        issued      = '0;
    end

    function automatic logic [31:0] apply_opcode(logic [3:0] op, logic [31:0] a, logic [31:0] b);
        case (op)
            isa_pkg::op_add:    return a + b;
            isa_pkg::op_sub:    return a - b;
            isa_pkg::op_and:    return a & b;
            isa_pkg::op_or:     return a | b;
            isa_pkg::op_xor:    return a ^ b;
            isa_pkg::op_pass_a: return a;
            default:            return '0;
        endcase
    endfunction

    task automatic compare(string name, logic [63:0] expected, logic [63:0] actual);
        check_count++;
        if (expected !== actual) begin
            error_count++;
            $display("FAILED %s: expected 0x%0h, got 0x%0h at %0t", name, expected, actual,
                     $time);
        end
    endtask

    // Everything is sampled on the falling edge, half a cycle after the DUT moved
    always @(negedge clock) begin : check_cycle
        logic [mem_map_pkg::mem_addr_w-1:0] addr [mem_map_pkg::lane_count];
        logic [mem_map_pkg::word_w-1:0]     opnd [mem_map_pkg::lane_count];
        logic [mem_map_pkg::lane_count-1:0][mem_map_pkg::io_port_count-1:0] rden_exp;
        logic                               hit [mem_map_pkg::lane_count];
        int                                 port [mem_map_pkg::lane_count];
        logic                               ready_exp;
        logic [isa_pkg::opcode_w-1:0]       op_eff;
        isa_pkg::wb_t                       exp_wb;
        isa_pkg::wb_t                       done_wb;
        if (rst) begin
            expect_q.delete();
            compare("wb_out.wren", 0, wb_out.wren);
            compare("io_rden", 0, io_rden);
            compare("io_ready", 1, io_ready);
        end else begin
            addr[0]   = issued.a;
            addr[1]   = issued.b;
            ready_exp = 1'b1;
            rden_exp  = '0;
            for (int l = 0; l < mem_map_pkg::lane_count; l++) begin
                hit[l]  = addr[l] >= mem_map_pkg::io_base_addr;
                port[l] = int'(addr[l]) - mem_map_pkg::io_base_addr;
                if (hit[l]) begin
                    opnd[l] = io_in[l].data[port[l]];
                    if (!io_in[l].ef[port[l]]) begin
                        ready_exp = 1'b0;
                    end
                end else begin
                    opnd[l] = mem_model[l][addr[l]];    // Writes still in flight are not seen
                end
            end
            for (int l = 0; l < mem_map_pkg::lane_count; l++) begin
                if (ready_exp && hit[l]) begin
                    rden_exp[l][port[l]] = 1'b1;
                end
            end
            compare("io_ready", ready_exp, io_ready);
            compare("io_rden", rden_exp, io_rden);
            if (!ready_exp) begin
                annul_count++;
            end
            op_eff         = ready_exp ? issued.op : isa_pkg::op_nop;
            exp_wb.d       = issued.d;
            exp_wb.wren    = op_eff >= isa_pkg::op_add && op_eff <= isa_pkg::op_pass_a;
            exp_wb.result  = apply_opcode(op_eff, opnd[0], opnd[1]);
            expect_q.push_back(exp_wb);
            if (expect_q.size() == 3) begin
                done_wb = expect_q.pop_front();
                compare("wb_out.wren", done_wb.wren, wb_out.wren);
                compare("wb_out.d", done_wb.d, wb_out.d);
                compare("wb_out.result", done_wb.result, wb_out.result);
                // This result reaches the lane memory on the next rising edge
                if (done_wb.wren) begin
                    mem_model[done_wb.d[isa_pkg::d_lane_bit]][done_wb.d[9:0]] = done_wb.result;
                end
            end
        end
        issued = instr_in;
    end

endmodule

// ==== dv/tb_datapath.sv ====
`timescale 1ns/1ps

module tb_datapath;

    localparam int clk_period   = 100;
    localparam int reset_cycles = 8;
    localparam int num_instr    = 2000;
    localparam int drain_cycles = 20;

    // Second RAM region, well below the I/O window
    localparam logic [4:0] upper_page = 5'b10110;

    logic                                                                   clock;
    logic                                                                   rst;
    isa_pkg::instr_t                                                        instr_in;
    mem_map_pkg::io_in_t [mem_map_pkg::lane_count-1:0]                      io_in;
    logic                                                                   io_ready;
    logic [mem_map_pkg::lane_count-1:0][mem_map_pkg::io_port_count-1:0]     io_rden;
    isa_pkg::wb_t                                                           wb_out;

    int seed;
    int check_count;
    int error_count;
    int annul_count;

    datapath_top i_dut (
        .clock      (clock),
        .rst        (rst),
        .instr_in   (instr_in),
        .io_in      (io_in),
        .io_ready   (io_ready),
        .io_rden    (io_rden),
        .wb_out     (wb_out)
    );

    datapath_checker i_checker (
        .clock       (clock),
        .rst         (rst),
        .instr_in    (instr_in),
        .io_in       (io_in),
        .io_ready    (io_ready),
        .io_rden     (io_rden),
        .wb_out      (wb_out),
        .check_count (check_count),
        .error_count (error_count),
        .annul_count (annul_count)
    );

    initial begin
        clock = 1'b0;
        forever #(clk_period / 2) clock = ~clock;
    end

    // A quarter of the reads land in the I/O window, the rest in two small regions so
    // that writes and later reads meet often
    function automatic logic [mem_map_pkg::mem_addr_w-1:0] random_read_addr();
        logic [31:0] r;
        r = $random(seed);
        if (r[7:6] == 2'b00) begin
            return mem_map_pkg::mem_addr_w'(mem_map_pkg::io_base_addr + r[1:0]);
        end
        return {r[5] ? upper_page : 5'b0, r[4:0]};
    endfunction

    task automatic drive_random_instr();
        isa_pkg::instr_t next_instr;
        logic [31:0]     r;
        r = $random(seed);
        next_instr.op = {r[3] & r[4], r[2:0]};    // Undecoded opcodes show up now and then
        next_instr.d  = {r[5], r[13] ? upper_page : 5'b0, r[12:8]};
        next_instr.a  = random_read_addr();
        next_instr.b  = random_read_addr();
        instr_in <= next_instr;
    endtask

    task automatic drive_random_io();
        mem_map_pkg::io_in_t [mem_map_pkg::lane_count-1:0] next_io;
        logic [31:0]                                       r;
        for (int l = 0; l < mem_map_pkg::lane_count; l++) begin
            for (int p = 0; p < mem_map_pkg::io_port_count; p++) begin
                next_io[l].data[p] = $random(seed);
                r = $random(seed);
                next_io[l].ef[p] = |r[1:0];    // Full three times out of four
            end
        end
        io_in <= next_io;
    endtask

    initial begin
        seed     = 32'h3076;
        rst      = 1'b1;
        instr_in = '0;
        io_in    = '0;
        repeat (reset_cycles) @(posedge clock);
        rst <= 1'b0;
        for (int n = 0; n < num_instr; n++) begin
            @(posedge clock);
            drive_random_instr();
            drive_random_io();
        end
        @(posedge clock);
        instr_in <= '0;
        repeat (5) @(posedge clock);
        @(negedge clock);
        $display("checks: %0d  errors: %0d  annulled: %0d", check_count, error_count,
                 annul_count);
        if (error_count == 0 && check_count > 0) begin
            $display("TEST PASS");
        end else begin
            if (check_count == 0) begin
                $display("No checks were made during the run");
            end
            $display("TEST FAIL");
        end
        $finish;
    end

    initial begin
        #((num_instr + reset_cycles + drain_cycles) * clk_period);
        $display("Timeout: the run did not finish within %0d cycles",
                 num_instr + reset_cycles + drain_cycles);
        $display("TEST FAIL");
        $finish;
    end

endmodule

// ==== source/alu.sv ====
`timescale 1ns/1ps

module alu (
    input  logic                           clock,
    input  logic                           rst,
    input  isa_pkg::ctrl_t                 ctrl,
    input  logic [mem_map_pkg::word_w-1:0] a,
    input  logic [mem_map_pkg::word_w-1:0] b,
    output isa_pkg::wb_t                   wb
);

    isa_pkg::wb_t wb_next;

    always_comb begin
        wb_next.d      = ctrl.d;
        wb_next.wren   = 1'b1;
        wb_next.result = '0;
        case (ctrl.op)
            isa_pkg::op_add: begin
                wb_next.result = a + b;
            end
            isa_pkg::op_sub: begin
                wb_next.result = a - b;
            end
            isa_pkg::op_and: begin
                wb_next.result = a & b;
            end
            isa_pkg::op_or: begin
                wb_next.result = a | b;
            end
            isa_pkg::op_xor: begin
                wb_next.result = a ^ b;
            end
            isa_pkg::op_pass_a: begin
                wb_next.result = a;
            end
            default: begin
                wb_next.wren = 1'b0;    // NOP, annulled or undecoded opcode
            end
        endcase
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            wb <= '0;
        end else begin
            wb <= wb_next;
        end
    end

endmodule

// ==== source/datapath_top.sv ====
`timescale 1ns/1ps

module datapath_top (
    input  logic                                                            clock,
    input  logic                                                            rst,
    input  isa_pkg::instr_t                                                 instr_in,
    input  mem_map_pkg::io_in_t [mem_map_pkg::lane_count-1:0]               io_in,
    output logic                                                            io_ready,
    output logic [mem_map_pkg::lane_count-1:0][mem_map_pkg::io_port_count-1:0] io_rden,
    output isa_pkg::wb_t                                                    wb_out
);

    logic [mem_map_pkg::lane_count-1:0][mem_map_pkg::mem_addr_w-1:0] read_addr;
    logic [mem_map_pkg::lane_count-1:0]                              blocked;
    logic [mem_map_pkg::lane_count-1:0][mem_map_pkg::word_w-1:0]     operand;
    isa_pkg::ctrl_t                                                  ctrl_issue;
    isa_pkg::ctrl_t                                                  ctrl_exec;

    issue_stage i_issue (
        .clock      (clock),
        .rst        (rst),
        .instr_in   (instr_in),
        .blocked    (blocked),
        .read_addr  (read_addr),
        .io_ready   (io_ready),
        .ctrl       (ctrl_issue)
    );

    // Keeps the control in step with the operand read
    delay_line #(
        .depth      (1),
        .payload_t  (isa_pkg::ctrl_t)
    ) i_ctrl_pipe (
        .clock      (clock),
        .rst        (rst),
        .in         (ctrl_issue),
        .out        (ctrl_exec)
    );

    for (genvar lane = 0; lane < mem_map_pkg::lane_count; lane++) begin : g_lane
        operand_lane #(
            .lane_id    (lane)
        ) i_lane (
            .clock      (clock),
            .rst        (rst),
            .read_addr  (read_addr[lane]),
            .io_ready   (io_ready),
            .io_in      (io_in[lane]),
            .wb         (wb_out),
            .blocked    (blocked[lane]),
            .io_rden    (io_rden[lane]),
            .operand    (operand[lane])
        );
    end

    alu i_alu (
        .clock      (clock),
        .rst        (rst),
        .ctrl       (ctrl_exec),
        .a          (operand[0]),
        .b          (operand[1]),
        .wb         (wb_out)
    );

endmodule

// ==== source/delay_line.sv ====
`timescale 1ns/1ps

module delay_line #(
    parameter int  depth     = 1,
    parameter type payload_t = logic
) (
    input  logic     clock,
    input  logic     rst,
    input  payload_t in,
    output payload_t out
);

    payload_t stage [depth];

    always_ff @(posedge clock) begin
        if (rst) begin
            for (int i = 0; i < depth; i++) begin
                stage[i] <= '0;
            end
        end else begin
            stage[0] <= in;
            for (int i = 1; i < depth; i++) begin
                stage[i] <= stage[i-1];
            end
        end
    end

    assign out = stage[depth-1];

endmodule

// ==== source/isa_pkg.sv ====
package isa_pkg;

    localparam int opcode_w    = 4;
    localparam int a_operand_w = 10;
    localparam int b_operand_w = 10;
    localparam int d_operand_w = 11;
    localparam int instr_w     = opcode_w + d_operand_w + a_operand_w + b_operand_w;

    localparam int d_lane_bit  = 10;    // D bit that picks the writeback lane

    // Opcodes 7 to 15 are not decoded and behave as a NOP
    localparam logic [opcode_w-1:0] op_nop    = 4'd0;
    localparam logic [opcode_w-1:0] op_add    = 4'd1;
    localparam logic [opcode_w-1:0] op_sub    = 4'd2;
    localparam logic [opcode_w-1:0] op_and    = 4'd3;
    localparam logic [opcode_w-1:0] op_or     = 4'd4;
    localparam logic [opcode_w-1:0] op_xor    = 4'd5;
    localparam logic [opcode_w-1:0] op_pass_a = 4'd6;

    typedef struct packed {
        logic [opcode_w-1:0]    op;
        logic [d_operand_w-1:0] d;
        logic [a_operand_w-1:0] a;
        logic [b_operand_w-1:0] b;
    } instr_t;

    // What the ALU still needs once the operands are fetched
    typedef struct packed {
        logic [opcode_w-1:0]    op;
        logic [d_operand_w-1:0] d;
    } ctrl_t;

    typedef struct packed {
        logic                            wren;
        logic [d_operand_w-1:0]          d;
        logic [mem_map_pkg::word_w-1:0]  result;
    } wb_t;

endpackage

// ==== source/issue_stage.sv ====
`timescale 1ns/1ps

module issue_stage (
    input  logic                                                         clock,
    input  logic                                                         rst,
    input  isa_pkg::instr_t                                              instr_in,
    input  logic [mem_map_pkg::lane_count-1:0]                           blocked,
    output logic [mem_map_pkg::lane_count-1:0][mem_map_pkg::mem_addr_w-1:0] read_addr,
    output logic                                                         io_ready,
    output isa_pkg::ctrl_t                                               ctrl
);

    isa_pkg::instr_t instr_q;

    // An all-zero instruction is a NOP reading address 0 of both lanes
    always_ff @(posedge clock) begin
        if (rst) begin
            instr_q <= '0;
        end else begin
            instr_q <= instr_in;
        end
    end

    assign read_addr[0] = instr_q.a;    // Lane 0 serves operand A
    assign read_addr[1] = instr_q.b;

    // One empty port anywhere holds the whole instruction back
    assign io_ready = ~|blocked;

    always_comb begin
        ctrl.d = instr_q.d;
        if (io_ready) begin
            ctrl.op = instr_q.op;
        end else begin
            ctrl.op = isa_pkg::op_nop;  // Left for the surrounding control to replay
        end
    end

endmodule

// ==== source/mem_map_pkg.sv ====
package mem_map_pkg;

    localparam int word_w        = 32;
    localparam int lane_count    = 2;
    localparam int mem_depth     = 1024;
    localparam int mem_addr_w    = 10;

    // The read ports sit at the top four words of each lane
    localparam int io_port_count = 4;
    localparam int io_port_w     = 2;
    localparam int io_base_addr  = 1020;

    typedef struct packed {
        logic [io_port_count-1:0]             ef;    // High when the port holds data
        logic [io_port_count-1:0][word_w-1:0] data;
    } io_in_t;

    typedef struct packed {
        logic                 hit;
        logic [io_port_w-1:0] port;
    } io_sel_t;

endpackage

// ==== source/operand_lane.sv ====
`timescale 1ns/1ps

module operand_lane #(
    parameter int lane_id = 0
) (
    input  logic                                 clock,
    input  logic                                 rst,
    input  logic [mem_map_pkg::mem_addr_w-1:0]   read_addr,
    input  logic                                 io_ready,
    input  mem_map_pkg::io_in_t                  io_in,
    input  isa_pkg::wb_t                         wb,
    output logic                                 blocked,
    output logic [mem_map_pkg::io_port_count-1:0] io_rden,
    output logic [mem_map_pkg::word_w-1:0]       operand
);

    logic [mem_map_pkg::word_w-1:0]     mem [mem_map_pkg::mem_depth];
    logic [mem_map_pkg::word_w-1:0]     ram_q;
    logic [mem_map_pkg::word_w-1:0]     io_data_q;
    logic [mem_map_pkg::mem_addr_w-1:0] io_offset;
    logic [mem_map_pkg::mem_addr_w-1:0] write_addr;
    logic                               lane_wren;
    mem_map_pkg::io_sel_t               sel;
    mem_map_pkg::io_sel_t               sel_q;

    initial begin
        for (int i = 0; i < mem_map_pkg::mem_depth; i++) begin
            mem[i] = '0;
        end
    end

    // Addresses below the port window wrap to a large offset and miss
    assign io_offset = read_addr - mem_map_pkg::mem_addr_w'(mem_map_pkg::io_base_addr);

    always_comb begin
        sel.hit  = io_offset < mem_map_pkg::io_port_count;
        sel.port = io_offset[mem_map_pkg::io_port_w-1:0];
    end

    assign blocked = sel.hit & ~io_in.ef[sel.port];

    // The port is consumed only if no lane annuls the instruction
    always_comb begin
        io_rden = '0;
        if (io_ready && sel.hit) begin
            io_rden[sel.port] = 1'b1;
        end
    end

    // Writeback goes to this lane when D bit 10 names it
    assign lane_wren  = wb.wren && (wb.d[isa_pkg::d_lane_bit] == 1'(lane_id));
    assign write_addr = wb.d[mem_map_pkg::mem_addr_w-1:0];

    always_ff @(posedge clock) begin
        if (lane_wren) begin
            mem[write_addr] <= wb.result;
        end
        ram_q     <= mem[read_addr];    // Read before write on the same address
        io_data_q <= io_in.data[sel.port];
    end

    // Tells the output mux, one cycle on, which source the address picked
    delay_line #(
        .depth      (1),
        .payload_t  (mem_map_pkg::io_sel_t)
    ) i_sel_pipe (
        .clock      (clock),
        .rst        (rst),
        .in         (sel),
        .out        (sel_q)
    );

    assign operand = sel_q.hit ? io_data_q : ram_q;

endmodule
